// File: Makefile
TOP = tb_lb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f -o sim

run: build
	./obj_dir/sim | tee sim.log
	@if grep -q ">>> FAIL" sim.log || ! grep -q ">>> PASS" sim.log; then \
	  echo "Simulation failed, see sim.log"; \
	  exit 1; \
	fi

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir sim.log

// File: sources.f
verilog/lb_pkg.sv
verilog/axis_reg_slice.sv
verilog/lb_controller.sv
verilog/lb_hash_policy.sv
verilog/lb_top.sv
test/lb_assert.sv
test/tb_lb.sv

// File: test/lb_assert.sv
// Load balancer stream checks
`timescale 1ns/1ns
`default_nettype none

module lb_assert (
  input logic                              clk,
  input logic                              rst_n,
  input logic [lb_pkg::DATA_WIDTH-1:0]     data_m_tdata,
  input logic [lb_pkg::KEEP_WIDTH-1:0]     data_m_tkeep,
  input logic                              data_m_tlast,
  input logic [lb_pkg::CORE_ID_WIDTH-1:0]  data_m_tdest,
  input logic [lb_pkg::TAG_WIDTH-1:0]      data_m_tuser,
  input logic                              data_m_tvalid,
  input logic                              data_m_tready,
  input logic [lb_pkg::DATA_WIDTH-1:0]     tx_tdata,
  input logic [lb_pkg::KEEP_WIDTH-1:0]     tx_tkeep,
  input logic                              tx_tlast,
  input logic                              tx_tvalid,
  input logic                              tx_tready,
  input logic [lb_pkg::CORE_COUNT-1:0]     enabled_cores
);

  logic first_q;

  // Next data_m beat opens a packet
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_q <= 1'b1;
    end else if (data_m_tvalid && data_m_tready) begin
      first_q <= data_m_tlast;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Handshake stability
  //////////////////////////////////////////////////////////////////////
  // Stalled beat towards the cores holds still until taken
  a_m_stable: assert property (@(posedge clk) disable iff (!rst_n)
    data_m_tvalid && !data_m_tready |=> data_m_tvalid &&
      $stable({data_m_tdata, data_m_tkeep, data_m_tlast, data_m_tdest, data_m_tuser}))
    else $error("data_m payload changed while stalled");

  // Same rule on the transmit side
  a_tx_stable: assert property (@(posedge clk) disable iff (!rst_n)
    tx_tvalid && !tx_tready |=> tx_tvalid && $stable({tx_tdata, tx_tkeep, tx_tlast}))
    else $error("tx payload changed while stalled");

  // First beat on data_m names a core that is enabled
  a_dest_enabled: assert property (@(posedge clk) disable iff (!rst_n)
    data_m_tvalid && first_q |-> enabled_cores[data_m_tdest])
    else $error("first beat forwarded to a disabled core");

  // No valid output while reset is held
  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !data_m_tvalid && !tx_tvalid)
    else $error("valid output high during reset");

endmodule

bind lb_top lb_assert lb_checks (
  .clk(clk), .rst_n(rst_n),
  .data_m_tdata(data_m_tdata), .data_m_tkeep(data_m_tkeep), .data_m_tlast(data_m_tlast),
  .data_m_tdest(data_m_tdest), .data_m_tuser(data_m_tuser),
  .data_m_tvalid(data_m_tvalid), .data_m_tready(data_m_tready),
  .tx_tdata(tx_tdata), .tx_tkeep(tx_tkeep), .tx_tlast(tx_tlast),
  .tx_tvalid(tx_tvalid), .tx_tready(tx_tready),
  .enabled_cores(policy.enabled_cores)
);

`default_nettype wire

// File: test/tb_lb.sv
// Load balancer testbench
`timescale 1ns/1ns
`default_nettype none

module tb_lb;

  // Cycles allowed per beat
  localparam int TIMEOUT = 100;

  logic                                 clk;
  logic                                 rst_n;
  logic [lb_pkg::DATA_WIDTH-1:0]        rx_tdata;
  logic [lb_pkg::KEEP_WIDTH-1:0]        rx_tkeep;
  logic                                 rx_tvalid;
  logic                                 rx_tready;
  logic                                 rx_tlast;
  logic [lb_pkg::DATA_WIDTH-1:0]        tx_tdata;
  logic [lb_pkg::KEEP_WIDTH-1:0]        tx_tkeep;
  logic                                 tx_tvalid;
  logic                                 tx_tready;
  logic                                 tx_tlast;
  logic [lb_pkg::DATA_WIDTH-1:0]        data_m_tdata;
  logic [lb_pkg::KEEP_WIDTH-1:0]        data_m_tkeep;
  logic [lb_pkg::CORE_ID_WIDTH-1:0]     data_m_tdest;
  logic [lb_pkg::TAG_WIDTH-1:0]         data_m_tuser;
  logic                                 data_m_tvalid;
  logic                                 data_m_tready;
  logic                                 data_m_tlast;
  logic [lb_pkg::DATA_WIDTH-1:0]        data_s_tdata;
  logic [lb_pkg::KEEP_WIDTH-1:0]        data_s_tkeep;
  logic                                 data_s_tvalid;
  logic                                 data_s_tready;
  logic                                 data_s_tlast;
  logic                                 ctrl_s_valid;
  logic [lb_pkg::CORE_ID_WIDTH-1:0]     ctrl_s_core;
  logic [lb_pkg::TAG_WIDTH-1:0]         ctrl_s_tag;
  logic [lb_pkg::HOST_ADDR_WIDTH-1:0]   host_cmd_addr;
  logic [31:0]                          host_cmd_wr_data;
  logic                                 host_cmd_wr_en;
  logic [31:0]                          host_cmd_rd_data;

  //////////////////////////////////////////////////////////////////////
  // Scoreboard state
  //////////////////////////////////////////////////////////////////////
  logic [lb_pkg::TAG_WIDTH-1:0]  free_list [lb_pkg::CORE_COUNT][$];
  logic [lb_pkg::CORE_COUNT-1:0] model_enable;
  int                            model_drops;
  // Expected beats in order on data_m and on tx
  lb_pkg::core_beat_t            m_exp_q [$];
  lb_pkg::rx_beat_t              tx_exp_q [$];
  // Cycle stamps of first-beat transfers for latency checks
  int                            cycle = 0;
  int                            rx_accept_cycle;
  int                            tx_accept_cycle;
  logic                          bp_en;

  lb_top DUT (.*);

  always #4 clk = ~clk;

  // Stable at the falling edge where all sampling happens
  always @(posedge clk) cycle <= cycle + 1;

  //////////////////////////////////////////////////////////////////////
  // Reporting and helpers
  //////////////////////////////////////////////////////////////////////
  task automatic report_failure(input string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else
      report_failure($sformatf("ERROR time %0t: %s = %0h, expected %0h",
                               $time, name, got, exp));
  endtask

  // XOR of bytes 0 to 3 with the low bits naming the core
  function automatic logic [1:0] flow_core(input logic [63:0] d);
    logic [7:0] x;
    x = d[7:0] ^ d[15:8] ^ d[23:16] ^ d[31:24];
    return x[1:0];
  endfunction

  // Full free lists with tags 0 to 3 for every core in the mask
  task automatic refill_model(input logic [lb_pkg::CORE_COUNT-1:0] mask);
    for (int c = 0; c < lb_pkg::CORE_COUNT; c++) begin
      if (mask[c]) begin
        free_list[c].delete();
        for (int t = 0; t < lb_pkg::SLOT_COUNT; t++) begin
          free_list[c].push_back(2'(t));
        end
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Receive side driver and monitor
  //////////////////////////////////////////////////////////////////////
  task automatic send_packet(input logic [1:0] core, input int len);
    lb_pkg::rx_beat_t   beats [$];
    lb_pkg::rx_beat_t   b;
    lb_pkg::core_beat_t e;
    logic               fwd;
    logic [1:0]         tag;
    int                 n;
    for (int i = 0; i < len; i++) begin
      b.data = {$urandom, $urandom};
      // Steer byte 0 so the hash lands on the chosen core
      if (i == 0) b.data[1:0] = b.data[1:0] ^ flow_core(b.data) ^ core;
      b.last = (i == len - 1);
      b.keep = b.last ? 8'hff >> ($urandom % 8) : 8'hff;
      beats.push_back(b);
    end
    // Decision as the design must take it on the first beat
    fwd = model_enable[core] && (free_list[core].size() > 0);
    tag = '0;
    if (fwd) begin
      tag = free_list[core].pop_front();
      foreach (beats[i]) begin
        e.data = beats[i].data;
        e.keep = beats[i].keep;
        e.last = beats[i].last;
        e.dest = core;
        e.user = tag;
        m_exp_q.push_back(e);
      end
    end else begin
      model_drops++;
    end
    foreach (beats[i]) begin
      rx_tdata  = beats[i].data;
      rx_tkeep  = beats[i].keep;
      rx_tlast  = beats[i].last;
      rx_tvalid = 1'b1;
      n = 0;
      #1;
      while (!rx_tready) begin
        n++;
        assert (n < TIMEOUT) else report_failure("Timeout, rx_tready stayed low");
        @(negedge clk);
        #1;
      end
      if (i == 0) rx_accept_cycle = cycle;
      @(negedge clk);
    end
    rx_tvalid = 1'b0;
  endtask

  // Takes one packet from data_m
  // A zero exp_lat skips the latency check
  task automatic expect_packet(input int exp_lat);
    lb_pkg::core_beat_t e;
    logic               done;
    logic               seen;
    int                 n;
    done = 1'b0;
    seen = 1'b0;
    n    = 0;
    while (!done) begin
      data_m_tready = bp_en ? ($urandom % 2 == 0) : 1'b1;
      #1;
      if (data_m_tvalid && !seen) begin
        seen = 1'b1;
        if (exp_lat > 0) begin
          check_value("data_m_tvalid latency", 64'(cycle - rx_accept_cycle), 64'(exp_lat));
        end
      end
      if (data_m_tvalid && data_m_tready) begin
        assert (m_exp_q.size() > 0) else report_failure("Beat on data_m with none expected");
        e = m_exp_q.pop_front();
        check_value("data_m_tdata", data_m_tdata, e.data);
        check_value("data_m_tkeep", 64'(data_m_tkeep), 64'(e.keep));
        check_value("data_m_tlast", 64'(data_m_tlast), 64'(e.last));
        check_value("data_m_tdest", 64'(data_m_tdest), 64'(e.dest));
        check_value("data_m_tuser", 64'(data_m_tuser), 64'(e.user));
        done = e.last;
        n    = 0;
      end else begin
        n++;
        assert (n < TIMEOUT) else report_failure("Timeout waiting for a beat on data_m");
      end
      @(negedge clk);
    end
    data_m_tready = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Transmit side driver and monitor
  //////////////////////////////////////////////////////////////////////
  task automatic send_tx_packet(input int len);
    lb_pkg::rx_beat_t b;
    int               n;
    for (int i = 0; i < len; i++) begin
      b.data = {$urandom, $urandom};
      b.last = (i == len - 1);
      b.keep = b.last ? 8'hff >> ($urandom % 8) : 8'hff;
      tx_exp_q.push_back(b);
      data_s_tdata  = b.data;
      data_s_tkeep  = b.keep;
      data_s_tlast  = b.last;
      data_s_tvalid = 1'b1;
      n = 0;
      #1;
      while (!data_s_tready) begin
        n++;
        assert (n < TIMEOUT) else report_failure("Timeout, data_s_tready stayed low");
        @(negedge clk);
        #1;
      end
      if (i == 0) tx_accept_cycle = cycle;
      @(negedge clk);
    end
    data_s_tvalid = 1'b0;
  endtask

  task automatic expect_tx_packet(input int exp_lat);
    lb_pkg::rx_beat_t e;
    logic             done;
    logic             seen;
    int               n;
    done = 1'b0;
    seen = 1'b0;
    n    = 0;
    while (!done) begin
      tx_tready = bp_en ? ($urandom % 2 == 0) : 1'b1;
      #1;
      if (tx_tvalid && !seen) begin
        seen = 1'b1;
        if (exp_lat > 0) begin
          check_value("tx_tvalid latency", 64'(cycle - tx_accept_cycle), 64'(exp_lat));
        end
      end
      if (tx_tvalid && tx_tready) begin
        assert (tx_exp_q.size() > 0) else report_failure("Beat on tx with none expected");
        e = tx_exp_q.pop_front();
        check_value("tx_tdata", tx_tdata, e.data);
        check_value("tx_tkeep", 64'(tx_tkeep), 64'(e.keep));
        check_value("tx_tlast", 64'(tx_tlast), 64'(e.last));
        done = e.last;
        n    = 0;
      end else begin
        n++;
        assert (n < TIMEOUT) else report_failure("Timeout waiting for a beat on tx");
      end
      @(negedge clk);
    end
    tx_tready = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Release strobe and host commands
  //////////////////////////////////////////////////////////////////////
  task automatic release_slot(input logic [1:0] core, input logic [1:0] tag);
    ctrl_s_valid = 1'b1;
    ctrl_s_core  = core;
    ctrl_s_tag   = tag;
    if (free_list[core].size() < lb_pkg::SLOT_COUNT) free_list[core].push_back(tag);
    @(negedge clk);
    ctrl_s_valid = 1'b0;
  endtask

  task automatic host_write(input logic [1:0] addr, input logic [31:0] data);
    host_cmd_addr    = addr;
    host_cmd_wr_data = data;
    host_cmd_wr_en   = 1'b1;
    if (addr == lb_pkg::CMD_ENABLE) model_enable = data[lb_pkg::CORE_COUNT-1:0];
    if (addr == lb_pkg::CMD_FLUSH) refill_model(data[lb_pkg::CORE_COUNT-1:0]);
    @(negedge clk);
    host_cmd_wr_en = 1'b0;
  endtask

  task automatic host_read(input logic [1:0] addr, output logic [31:0] data);
    host_cmd_addr = addr;
    #1;
    data = host_cmd_rd_data;
    @(negedge clk);
  endtask

  // Slot counts and drop count against the model
  task automatic check_counters();
    logic [31:0] slots_exp;
    logic [31:0] slots_got;
    logic [31:0] drops_got;
    slots_exp = '0;
    for (int c = 0; c < lb_pkg::CORE_COUNT; c++) begin
      slots_exp[c*8 +: 8] = 8'(free_list[c].size());
    end
    host_read(lb_pkg::CMD_SLOTS, slots_got);
    check_value("host_cmd_rd_data CMD_SLOTS", 64'(slots_got), 64'(slots_exp));
    host_read(lb_pkg::CMD_DROPS, drops_got);
    check_value("host_cmd_rd_data CMD_DROPS", 64'(drops_got), 64'(model_drops));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] rd;
    void'($urandom(14119));
    clk = 1'b0;
    rst_n = 1'b0;
    {rx_tdata, rx_tkeep, rx_tvalid, rx_tlast} = '0;
    {data_s_tdata, data_s_tkeep, data_s_tvalid, data_s_tlast} = '0;
    data_m_tready = 1'b0;
    tx_tready     = 1'b0;
    {ctrl_s_valid, ctrl_s_core, ctrl_s_tag} = '0;
    {host_cmd_addr, host_cmd_wr_data, host_cmd_wr_en} = '0;
    bp_en        = 1'b0;
    model_enable = '1;
    model_drops  = 0;
    refill_model('1);
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // Counters straight out of reset
    check_counters();

    // Core 1 takes tags 0 to 3 in order while the other cores get one packet each
    for (int i = 0; i < 4; i++) begin
      fork
        send_packet(2'd1, i + 1);
        expect_packet(2);
      join
    end
    for (int c = 0; c < lb_pkg::CORE_COUNT; c++) begin
      if (c != 1) begin
        fork
          send_packet(2'(c), 2);
          expect_packet(2);
        join
      end
    end
    check_counters();

    // Core 1 is out of slots so this one drops
    send_packet(2'd1, 2);
    check_counters();
    release_slot(2'd1, 2'd2);
    check_counters();
    fork
      send_packet(2'd1, 1);
      expect_packet(2);
    join

    // Core 2 disabled while core 0 is still served
    host_write(lb_pkg::CMD_ENABLE, 32'hb);
    host_read(lb_pkg::CMD_ENABLE, rd);
    check_value("host_cmd_rd_data CMD_ENABLE", 64'(rd), 64'(model_enable));
    send_packet(2'd2, 3);
    fork
      send_packet(2'd0, 2);
      expect_packet(2);
    join
    check_counters();
    host_write(lb_pkg::CMD_ENABLE, 32'hf);
    host_write(lb_pkg::CMD_FLUSH, 32'h6);
    check_counters();
    fork
      send_packet(2'd2, 2);
      expect_packet(2);
    join

    // Both directions at once under random back-pressure
    host_write(lb_pkg::CMD_FLUSH, 32'hf);
    bp_en = 1'b1;
    fork
      begin
        for (int i = 0; i < 8; i++) begin
          send_packet(2'(i), 1 + int'($urandom % 4));
        end
      end
      begin
        repeat (8) expect_packet(0);
      end
      begin
        repeat (6) send_tx_packet(1 + int'($urandom % 4));
      end
      begin
        repeat (6) expect_tx_packet(0);
      end
    join
    bp_en = 1'b0;
    check_counters();

    // Transmit latency with tx_tready held high
    fork
      send_tx_packet(3);
      expect_tx_packet(2);
    join

    assert (m_exp_q.size() == 0 && tx_exp_q.size() == 0) else
      report_failure("Expected beats never arrived");
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/axis_reg_slice.sv
// Stream register slice
`timescale 1ns/1ns
`default_nettype none

module axis_reg_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,

  // Upstream side
  input  payload_t s_payload,
  input  logic     s_valid,
  output logic     s_ready,

  // Downstream side
  output payload_t m_payload,
  output logic     m_valid,
  input  logic     m_ready
);

  payload_t payload_q;
  logic     valid_q;

  // Room when empty, or when the held beat leaves on this edge
  assign s_ready = !valid_q || m_ready;

  // Occupancy flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (s_ready) begin
      // Refill in the same cycle as draining keeps one beat per cycle
      valid_q <= s_valid;
    end
  end

  // Payload holding register
  always_ff @(posedge clk) begin
    if (s_valid && s_ready) begin
      payload_q <= s_payload;
    end
  end

  assign m_payload = payload_q;
  assign m_valid   = valid_q;

endmodule

`default_nettype wire

// File: verilog/lb_controller.sv
// Per-core slot tag lists
`timescale 1ns/1ns
`default_nettype none

module lb_controller (
  input  logic                                              clk,
  input  logic                                              rst_n,

  // Slot release strobe from the cores
  input  logic                                              ctrl_s_valid,
  input  logic [lb_pkg::CORE_ID_WIDTH-1:0]                  ctrl_s_core,
  input  logic [lb_pkg::TAG_WIDTH-1:0]                      ctrl_s_tag,

  // Per-core list refill
  input  logic [lb_pkg::CORE_COUNT-1:0]                     slots_flush,

  // Reservation port towards the policy
  input  logic [lb_pkg::CORE_ID_WIDTH-1:0]                  selected_core,
  input  logic                                              desc_pop,
  output logic                                              slot_avail,
  output logic [lb_pkg::TAG_WIDTH-1:0]                      desc_tag,

  // Free-slot counts with core 0 lowest
  output logic [lb_pkg::CORE_COUNT*lb_pkg::SLOT_CNT_WIDTH-1:0] slot_counts
);

  logic [lb_pkg::CORE_COUNT-1:0] pop_sel;
  logic [lb_pkg::CORE_COUNT-1:0] rel_sel;
  logic [lb_pkg::CORE_COUNT-1:0] avail_vec;
  logic [lb_pkg::TAG_WIDTH-1:0]  head_tag [lb_pkg::CORE_COUNT];

  // One-hot decode of pop and release targets
  always_comb begin
    pop_sel                = '0;
    rel_sel                = '0;
    pop_sel[selected_core] = desc_pop;
    rel_sel[ctrl_s_core]   = ctrl_s_valid;
  end

  //////////////////////////////////////////////////////////////////////
  // One circular free list per core
  //////////////////////////////////////////////////////////////////////
  for (genvar c = 0; c < lb_pkg::CORE_COUNT; c++) begin : g_core
    logic [lb_pkg::TAG_WIDTH-1:0]      tags_q [lb_pkg::SLOT_COUNT];
    logic [lb_pkg::TAG_WIDTH-1:0]      rd_ptr_q;
    logic [lb_pkg::TAG_WIDTH-1:0]      wr_ptr_q;
    logic [lb_pkg::SLOT_CNT_WIDTH-1:0] count_q;
    logic                              do_pop;
    logic                              do_rel;

    // Pop only from a non-empty list
    assign do_pop = pop_sel[c] && (count_q != '0);
    // Release into a full list only when a pop frees an entry alongside
    assign do_rel = rel_sel[c] &&
                    ((count_q != lb_pkg::SLOT_CNT_WIDTH'(lb_pkg::SLOT_COUNT)) || do_pop);

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        // Full list with tags 0 to SLOT_COUNT-1 in order
        for (int i = 0; i < lb_pkg::SLOT_COUNT; i++) begin
          tags_q[i] <= lb_pkg::TAG_WIDTH'(i);
        end
        rd_ptr_q <= '0;
        wr_ptr_q <= '0;
        count_q  <= lb_pkg::SLOT_CNT_WIDTH'(lb_pkg::SLOT_COUNT);
      end else if (slots_flush[c]) begin
        // Flush overrides pop and release for this core
        for (int i = 0; i < lb_pkg::SLOT_COUNT; i++) begin
          tags_q[i] <= lb_pkg::TAG_WIDTH'(i);
        end
        rd_ptr_q <= '0;
        wr_ptr_q <= '0;
        count_q  <= lb_pkg::SLOT_CNT_WIDTH'(lb_pkg::SLOT_COUNT);
      end else begin
        if (do_pop) begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
        if (do_rel) begin
          tags_q[wr_ptr_q] <= ctrl_s_tag;
          wr_ptr_q         <= wr_ptr_q + 1'b1;
        end
        // Pop and release together leave the count as it is
        if (do_pop && !do_rel) begin
          count_q <= count_q - 1'b1;
        end else if (do_rel && !do_pop) begin
          count_q <= count_q + 1'b1;
        end
      end
    end

    assign avail_vec[c] = (count_q != '0);
    assign head_tag[c]  = tags_q[rd_ptr_q];
    assign slot_counts[c*lb_pkg::SLOT_CNT_WIDTH +: lb_pkg::SLOT_CNT_WIDTH] = count_q;
  end

  // Answer for the core under decision
  assign slot_avail = avail_vec[selected_core];
  assign desc_tag   = head_tag[selected_core];

endmodule

`default_nettype wire

// File: verilog/lb_hash_policy.sv
// Hash-based core selection
`timescale 1ns/1ns
`default_nettype none

module lb_hash_policy (
  input  logic                                                 clk,
  input  logic                                                 rst_n,

  // Receive stream after the input slice
  input  lb_pkg::rx_beat_t                                     s_beat,
  input  logic                                                 s_valid,
  output logic                                                 s_ready,

  // Tagged stream towards the output slice
  output lb_pkg::core_beat_t                                   m_beat,
  output logic                                                 m_valid,
  input  logic                                                 m_ready,

  // Host command port
  input  logic [lb_pkg::HOST_ADDR_WIDTH-1:0]                   host_cmd_addr,
  input  logic [31:0]                                          host_cmd_wr_data,
  input  logic                                                 host_cmd_wr_en,
  output logic [31:0]                                          host_cmd_rd_data,

  // Slot status from the controller
  output logic [lb_pkg::CORE_COUNT-1:0]                        slots_flush,
  input  logic [lb_pkg::CORE_COUNT*lb_pkg::SLOT_CNT_WIDTH-1:0] slot_counts,

  // Reservation request and answer
  output logic [lb_pkg::CORE_ID_WIDTH-1:0]                     selected_core,
  input  logic                                                 slot_avail,
  input  logic [lb_pkg::TAG_WIDTH-1:0]                         desc_tag,
  output logic                                                 desc_pop
);

  typedef enum logic [1:0] {ST_IDLE, ST_FWD, ST_DROP} state_t;

  state_t                           state_q;
  logic [lb_pkg::CORE_COUNT-1:0]    enabled_cores;
  logic [31:0]                      drop_cnt_q;
  logic [lb_pkg::CORE_ID_WIDTH-1:0] core_q;
  logic [lb_pkg::TAG_WIDTH-1:0]     tag_q;
  logic [7:0]                       hash;
  logic                             fwd_ok;
  logic                             xfer;
  logic [31:0]                      slots_word;

  //////////////////////////////////////////////////////////////////////
  // First-beat decision
  //////////////////////////////////////////////////////////////////////
  // XOR of bytes 0 to 3, low bits pick the core
  assign hash = s_beat.data[7:0] ^ s_beat.data[15:8] ^
                s_beat.data[23:16] ^ s_beat.data[31:24];
  assign selected_core = hash[lb_pkg::CORE_ID_WIDTH-1:0];
  assign fwd_ok        = enabled_cores[selected_core] && slot_avail;

  always_comb begin
    m_beat.data = s_beat.data;
    m_beat.keep = s_beat.keep;
    m_beat.last = s_beat.last;
    m_beat.dest = core_q;
    m_beat.user = tag_q;
    m_valid     = 1'b0;
    s_ready     = 1'b1;
    case (state_q)
      ST_IDLE: begin
        // Head tag is used directly on the first beat
        m_beat.dest = selected_core;
        m_beat.user = desc_tag;
        if (fwd_ok) begin
          m_valid = s_valid;
          s_ready = m_ready;
        end
      end
      ST_FWD: begin
        m_valid = s_valid;
        s_ready = m_ready;
      end
      default: ;  // Drop state swallows beats
    endcase
  end

  assign xfer     = s_valid && s_ready;
  assign desc_pop = (state_q == ST_IDLE) && fwd_ok && s_valid && m_ready;

  // Packet state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else if (xfer) begin
      if (s_beat.last) begin
        state_q <= ST_IDLE;
      end else if (state_q == ST_IDLE) begin
        state_q <= fwd_ok ? ST_FWD : ST_DROP;
      end
    end
  end

  // Core and tag held for the rest of the packet
  always_ff @(posedge clk) begin
    if (desc_pop) begin
      core_q <= selected_core;
      tag_q  <= desc_tag;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Host registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enabled_cores <= '1;
      drop_cnt_q    <= '0;
    end else begin
      if (host_cmd_wr_en && host_cmd_addr == lb_pkg::CMD_ENABLE) begin
        enabled_cores <= host_cmd_wr_data[lb_pkg::CORE_COUNT-1:0];
      end
      // Count once per packet, at its first beat
      if (state_q == ST_IDLE && s_valid && !fwd_ok) begin
        drop_cnt_q <= drop_cnt_q + 1'b1;
      end
    end
  end

  // Flush is a single-cycle pulse straight from the write strobe
  assign slots_flush = (host_cmd_wr_en && host_cmd_addr == lb_pkg::CMD_FLUSH) ?
                       host_cmd_wr_data[lb_pkg::CORE_COUNT-1:0] : '0;

  // Readback, 8 bits per core count
  always_comb begin
    slots_word = '0;
    for (int c = 0; c < lb_pkg::CORE_COUNT; c++) begin
      slots_word[c*8 +: lb_pkg::SLOT_CNT_WIDTH] =
        slot_counts[c*lb_pkg::SLOT_CNT_WIDTH +: lb_pkg::SLOT_CNT_WIDTH];
    end
    case (host_cmd_addr)
      lb_pkg::CMD_ENABLE: host_cmd_rd_data = 32'(enabled_cores);
      lb_pkg::CMD_DROPS:  host_cmd_rd_data = drop_cnt_q;
      lb_pkg::CMD_SLOTS:  host_cmd_rd_data = slots_word;
      default:            host_cmd_rd_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/lb_pkg.sv
// Load balancer shared definitions
`default_nettype none

package lb_pkg;

  //////////////////////////////////////////////////////////////////////
  // Stream and core sizes
  //////////////////////////////////////////////////////////////////////
  localparam int DATA_WIDTH      = 64;
  localparam int KEEP_WIDTH      = DATA_WIDTH / 8;
  localparam int CORE_COUNT      = 4;
  localparam int CORE_ID_WIDTH   = 2;
  localparam int SLOT_COUNT      = 4;
  localparam int TAG_WIDTH       = 2;
  // Wide enough to hold SLOT_COUNT itself
  localparam int SLOT_CNT_WIDTH  = 3;
  localparam int HOST_ADDR_WIDTH = 2;

  //////////////////////////////////////////////////////////////////////
  // Host command addresses
  //////////////////////////////////////////////////////////////////////
  localparam logic [HOST_ADDR_WIDTH-1:0] CMD_ENABLE = 2'd0;
  localparam logic [HOST_ADDR_WIDTH-1:0] CMD_DROPS  = 2'd1;
  localparam logic [HOST_ADDR_WIDTH-1:0] CMD_SLOTS  = 2'd2;
  localparam logic [HOST_ADDR_WIDTH-1:0] CMD_FLUSH  = 2'd3;

  // Beat as seen on the Ethernet side, 73 bits
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [KEEP_WIDTH-1:0] keep;
    logic                  last;
  } rx_beat_t;

  // Beat towards the cores, tagged with core number and slot, 77 bits
  typedef struct packed {
    logic [DATA_WIDTH-1:0]    data;
    logic [KEEP_WIDTH-1:0]    keep;
    logic                     last;
    logic [CORE_ID_WIDTH-1:0] dest;
    logic [TAG_WIDTH-1:0]     user;
  } core_beat_t;

endpackage

`default_nettype wire

// File: verilog/lb_top.sv
// Packet load balancer top
`timescale 1ns/1ns
`default_nettype none

module lb_top (
  input  logic                                 clk,
  input  logic                                 rst_n,

  // Ethernet receive and transmit
  input  logic [lb_pkg::DATA_WIDTH-1:0]        rx_tdata,
  input  logic [lb_pkg::KEEP_WIDTH-1:0]        rx_tkeep,
  input  logic                                 rx_tvalid,
  output logic                                 rx_tready,
  input  logic                                 rx_tlast,
  output logic [lb_pkg::DATA_WIDTH-1:0]        tx_tdata,
  output logic [lb_pkg::KEEP_WIDTH-1:0]        tx_tkeep,
  output logic                                 tx_tvalid,
  input  logic                                 tx_tready,
  output logic                                 tx_tlast,

  // Streams to and from the cores
  output logic [lb_pkg::DATA_WIDTH-1:0]        data_m_tdata,
  output logic [lb_pkg::KEEP_WIDTH-1:0]        data_m_tkeep,
  output logic [lb_pkg::CORE_ID_WIDTH-1:0]     data_m_tdest,
  output logic [lb_pkg::TAG_WIDTH-1:0]         data_m_tuser,
  output logic                                 data_m_tvalid,
  input  logic                                 data_m_tready,
  output logic                                 data_m_tlast,
  input  logic [lb_pkg::DATA_WIDTH-1:0]        data_s_tdata,
  input  logic [lb_pkg::KEEP_WIDTH-1:0]        data_s_tkeep,
  input  logic                                 data_s_tvalid,
  output logic                                 data_s_tready,
  input  logic                                 data_s_tlast,

  // Slot release strobe
  input  logic                                 ctrl_s_valid,
  input  logic [lb_pkg::CORE_ID_WIDTH-1:0]     ctrl_s_core,
  input  logic [lb_pkg::TAG_WIDTH-1:0]         ctrl_s_tag,

  // Host commands
  input  logic [lb_pkg::HOST_ADDR_WIDTH-1:0]   host_cmd_addr,
  input  logic [31:0]                          host_cmd_wr_data,
  input  logic                                 host_cmd_wr_en,
  output logic [31:0]                          host_cmd_rd_data
);

  lb_pkg::rx_beat_t   rx_in, rx_beat, tx_in, tx_mid, tx_out;
  lb_pkg::core_beat_t pol_beat, out_beat;
  logic rx_valid, rx_ready, pol_valid, pol_ready, tx_mid_valid, tx_mid_ready;
  logic [lb_pkg::CORE_COUNT-1:0]                        slots_flush;
  logic [lb_pkg::CORE_COUNT*lb_pkg::SLOT_CNT_WIDTH-1:0] slot_counts;
  logic [lb_pkg::CORE_ID_WIDTH-1:0]                     selected_core;
  logic                                                 slot_avail;
  logic [lb_pkg::TAG_WIDTH-1:0]                         desc_tag;
  logic                                                 desc_pop;

  //////////////////////////////////////////////////////////////////////
  // Receive path, rx slice then policy then output slice
  //////////////////////////////////////////////////////////////////////
  assign rx_in = '{data: rx_tdata, keep: rx_tkeep, last: rx_tlast};

  axis_reg_slice #(.payload_t(lb_pkg::rx_beat_t)) rx_slice (
    .clk(clk), .rst_n(rst_n),
    .s_payload(rx_in), .s_valid(rx_tvalid), .s_ready(rx_tready),
    .m_payload(rx_beat), .m_valid(rx_valid), .m_ready(rx_ready)
  );

  lb_hash_policy policy (
    .clk(clk), .rst_n(rst_n),
    .s_beat(rx_beat), .s_valid(rx_valid), .s_ready(rx_ready),
    .m_beat(pol_beat), .m_valid(pol_valid), .m_ready(pol_ready),
    .host_cmd_addr(host_cmd_addr), .host_cmd_wr_data(host_cmd_wr_data),
    .host_cmd_wr_en(host_cmd_wr_en), .host_cmd_rd_data(host_cmd_rd_data),
    .slots_flush(slots_flush), .slot_counts(slot_counts),
    .selected_core(selected_core), .slot_avail(slot_avail),
    .desc_tag(desc_tag), .desc_pop(desc_pop)
  );

  // Slot bookkeeping for every core
  lb_controller controller (
    .clk(clk), .rst_n(rst_n),
    .ctrl_s_valid(ctrl_s_valid), .ctrl_s_core(ctrl_s_core), .ctrl_s_tag(ctrl_s_tag),
    .slots_flush(slots_flush), .selected_core(selected_core), .desc_pop(desc_pop),
    .slot_avail(slot_avail), .desc_tag(desc_tag), .slot_counts(slot_counts)
  );

  axis_reg_slice #(.payload_t(lb_pkg::core_beat_t)) out_slice (
    .clk(clk), .rst_n(rst_n),
    .s_payload(pol_beat), .s_valid(pol_valid), .s_ready(pol_ready),
    .m_payload(out_beat), .m_valid(data_m_tvalid), .m_ready(data_m_tready)
  );

  assign data_m_tdata = out_beat.data;
  assign data_m_tkeep = out_beat.keep;
  assign data_m_tlast = out_beat.last;
  assign data_m_tdest = out_beat.dest;
  assign data_m_tuser = out_beat.user;

  //////////////////////////////////////////////////////////////////////
  // Transmit path, two slices with no processing
  //////////////////////////////////////////////////////////////////////
  assign tx_in = '{data: data_s_tdata, keep: data_s_tkeep, last: data_s_tlast};

  axis_reg_slice #(.payload_t(lb_pkg::rx_beat_t)) tx_slice0 (
    .clk(clk), .rst_n(rst_n),
    .s_payload(tx_in), .s_valid(data_s_tvalid), .s_ready(data_s_tready),
    .m_payload(tx_mid), .m_valid(tx_mid_valid), .m_ready(tx_mid_ready)
  );

  axis_reg_slice #(.payload_t(lb_pkg::rx_beat_t)) tx_slice1 (
    .clk(clk), .rst_n(rst_n),
    .s_payload(tx_mid), .s_valid(tx_mid_valid), .s_ready(tx_mid_ready),
    .m_payload(tx_out), .m_valid(tx_tvalid), .m_ready(tx_tready)
  );

  assign tx_tdata = tx_out.data;
  assign tx_tkeep = tx_out.keep;
  assign tx_tlast = tx_out.last;

endmodule

`default_nettype wire
